/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = frame_merge_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    // Release between edges
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/frame_merge_checker.sv */
`default_nettype none

module frame_merge_checker import merge_pkg::*; (
  input logic  clk,
  input logic  rst,
  input beat_t out_data,
  input logic  out_valid,
  input logic  out_ready,
  input logic  out_last,
  input port_t out_src,
  input logic  a_good,
  input logic  a_bad,
  input logic  a_overflow,
  input logic  b_good,
  input logic  b_bad,
  input logic  b_overflow
);

  // A stalled output beat must not change
  assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_data) && $stable(out_last) && $stable(out_src)))
    else $error("output beat changed while stalled");

  // No switch of source inside a frame
  assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_ready && !out_last) |=> $stable(out_src))
    else $error("source tag changed in the middle of a frame");

  assert property (@(posedge clk) disable iff (rst) a_good |=> !a_good)
    else $error("a_good lasted two cycles");
  assert property (@(posedge clk) disable iff (rst) a_bad |=> !a_bad)
    else $error("a_bad lasted two cycles");
  assert property (@(posedge clk) disable iff (rst) a_overflow |=> !a_overflow)
    else $error("a_overflow lasted two cycles");
  assert property (@(posedge clk) disable iff (rst) b_good |=> !b_good)
    else $error("b_good lasted two cycles");
  assert property (@(posedge clk) disable iff (rst) b_bad |=> !b_bad)
    else $error("b_bad lasted two cycles");
  assert property (@(posedge clk) disable iff (rst) b_overflow |=> !b_overflow)
    else $error("b_overflow lasted two cycles");

endmodule

`default_nettype wire

/* bench/frame_merge_tb.sv */
`default_nettype none

module frame_merge_tb import merge_pkg::*; ();

  localparam int n_slots   = 105;
  localparam int max_len   = 40;
  localparam int fate_good = 0;
  localparam int fate_bad  = 1;
  localparam int fate_ovf  = 2;

  logic  clk;
  logic  rst;
  beat_t a_data;
  logic  a_valid;
  logic  a_ready;
  logic  a_last;
  logic  a_user;
  beat_t b_data;
  logic  b_valid;
  logic  b_ready;
  logic  b_last;
  logic  b_user;
  beat_t out_data;
  logic  out_valid;
  logic  out_ready = 1'b1;
  logic  out_last;
  port_t out_src;
  logic  a_good;
  logic  a_bad;
  logic  a_overflow;
  logic  b_good;
  logic  b_bad;
  logic  b_overflow;

  integer seed;
  int     frame_len [2][n_slots];
  bit     frame_bad [2][n_slots];
  beat_t  frame_bytes [2][n_slots][max_len];
  beat_t  exp_bytes [2][$];
  int     exp_len [2][$];
  // Per port and per fate
  int     exp_count [2][3];
  int     pulse_count [2][3];
  int     rx_beats;
  int     cycles;
  int     cycle_limit;
  bit     random_ready;

  clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  frame_merge_top i_frame_merge_top (.*);

  bind frame_merge_top frame_merge_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_last   (out_last),
    .out_src    (out_src),
    .a_good     (a_good),
    .a_bad      (a_bad),
    .a_overflow (a_overflow),
    .b_good     (b_good),
    .b_bad      (b_bad),
    .b_overflow (b_overflow)
  );

  // Expected fate of a frame on an empty FIFO
  function automatic int frame_fate(input int len, input bit bad);
    if (bad) begin
      return fate_bad;
    end
    if (len > fifo_depth) begin
      return fate_ovf;
    end
    return fate_good;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      fail_run($sformatf("Error at time %0t: %s is %0d, expected %0d",
                         $time, what, actual, expected));
    end
  endtask

  task automatic drive_port(input int p, input beat_t data, input logic valid,
                            input logic last, input logic user);
    if (p == 0) begin
      a_data  = data;
      a_valid = valid;
      a_last  = last;
      a_user  = user;
    end else begin
      b_data  = data;
      b_valid = valid;
      b_last  = last;
      b_user  = user;
    end
  endtask

  task automatic set_slot(input int p, input int idx, input int len, input bit bad);
    frame_len[p][idx] = len;
    frame_bad[p][idx] = bad;
  endtask

  task automatic send_frame(input int p, input int idx);
    int len;
    bit bad;
    int fate;
    len = frame_len[p][idx];
    bad = frame_bad[p][idx];
    // One frame in flight per port keeps the fates predictable
    while (exp_len[p].size() != 0) begin
      @(negedge clk);
    end
    fate = frame_fate(len, bad);
    exp_count[p][fate]++;
    if (fate == fate_good) begin
      for (int k = 0; k < len; k++) begin
        exp_bytes[p].push_back(frame_bytes[p][idx][k]);
      end
      exp_len[p].push_back(len);
    end
    for (int k = 0; k < len; k++) begin
      @(negedge clk);
      drive_port(p, frame_bytes[p][idx][k], 1'b1, k == len - 1, bad && (k == len - 1));
      while (!(p == 0 ? a_ready : b_ready)) begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    drive_port(p, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wait_drained();
    while (exp_len[0].size() + exp_len[1].size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Output sink and comparison
  always @(negedge clk) begin
    if (random_ready) begin
      out_ready = ($unsigned($random(seed)) % 3) != 0;
    end else begin
      out_ready = 1'b1;
    end
    if (out_valid && out_ready) begin
      if (exp_bytes[out_src].size() == 0) begin
        fail_run($sformatf("Unexpected output beat from port %0d at time %0t",
                           out_src, $time));
      end else begin
        check_value(int'(out_data), int'(exp_bytes[out_src].pop_front()), "output data");
        rx_beats++;
        if (out_last) begin
          check_value(rx_beats, exp_len[out_src].pop_front(), "frame length");
          rx_beats = 0;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (a_good) pulse_count[0][fate_good]++;
    if (a_bad) pulse_count[0][fate_bad]++;
    if (a_overflow) pulse_count[0][fate_ovf]++;
    if (b_good) pulse_count[1][fate_good]++;
    if (b_bad) pulse_count[1][fate_bad]++;
    if (b_overflow) pulse_count[1][fate_ovf]++;
    cycles++;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("Timeout, the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int total_beats;
    rx_beats     = 0;
    cycles       = 0;
    random_ready = 1'b0;
    total_beats  = 0;
    drive_port(0, '0, 1'b0, 1'b0, 1'b0);
    drive_port(1, '0, 1'b0, 1'b0, 1'b0);
    seed = 78841;
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < n_slots; i++) begin
        frame_len[p][i] = int'($unsigned($random(seed)) % max_len) + 1;
        frame_bad[p][i] = (($random(seed) & 3) == 0);
        for (int k = 0; k < max_len; k++) begin
          frame_bytes[p][i][k] = beat_t'($random(seed));
        end
      end
    end
    // Directed frames sit in the first slots
    set_slot(0, 0, 5, 1'b0);
    set_slot(1, 0, 3, 1'b1);
    set_slot(0, 1, 40, 1'b0);
    set_slot(0, 2, 32, 1'b0);
    set_slot(0, 3, 6, 1'b0);
    set_slot(0, 4, 7, 1'b0);
    set_slot(1, 1, 9, 1'b0);
    set_slot(1, 2, 4, 1'b0);
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < n_slots; i++) begin
        // Port b never sends slots 3 and 4
        if (p == 0 || i < 3 || i >= 5) begin
          total_beats += frame_len[p][i];
        end
      end
    end
    cycle_limit = 4 * total_beats + 500;

    do @(posedge clk); while (rst);

    send_frame(0, 0);
    send_frame(1, 0);
    send_frame(0, 1);
    send_frame(0, 2);
    wait_drained();

    fork
      begin
        send_frame(0, 3);
        send_frame(0, 4);
      end
      begin
        send_frame(1, 1);
        send_frame(1, 2);
      end
    join
    wait_drained();

    random_ready = 1'b1;
    fork
      for (int i = 5; i < n_slots; i++) send_frame(0, i);
      for (int i = 5; i < n_slots; i++) send_frame(1, i);
    join
    wait_drained();
    // Status pulses follow the last beat by one cycle
    repeat (4) @(negedge clk);

    for (int p = 0; p < 2; p++) begin
      check_value(pulse_count[p][fate_good], exp_count[p][fate_good],
                  $sformatf("port %0d good pulses", p));
      check_value(pulse_count[p][fate_bad], exp_count[p][fate_bad],
                  $sformatf("port %0d bad pulses", p));
      check_value(pulse_count[p][fate_ovf], exp_count[p][fate_ovf],
                  $sformatf("port %0d overflow pulses", p));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
source/merge_pkg.sv
source/frame_stream_if.sv
source/frame_fifo.sv
source/frame_arbiter.sv
source/frame_merge_top.sv
bench/clock_gen.sv
bench/frame_merge_checker.sv
bench/frame_merge_tb.sv

/* source/frame_arbiter.sv */
`default_nettype none

module frame_arbiter import merge_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  frame_stream_if.sink a,
  frame_stream_if.sink b,
  output beat_t        out_data,
  output logic         out_valid,
  input  logic         out_ready,
  output logic         out_last,
  output port_t        out_src
);

  arb_state_t state_q;
  arb_state_t state_d;
  port_t      last_src_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (a.valid && b.valid) begin
          // Contention goes to the port not served last
          state_d = (last_src_q == 1'b0) ? pass_b : pass_a;
        end else if (a.valid) begin
          state_d = pass_a;
        end else if (b.valid) begin
          state_d = pass_b;
        end
      end
      pass_a: begin
        if (a.valid && out_ready && a.last) begin
          state_d = idle;
        end
      end
      pass_b: begin
        if (b.valid && out_ready && b.last) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= idle;
      last_src_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_d == pass_a) begin
        last_src_q <= 1'b0;
      end else if (state_d == pass_b) begin
        last_src_q <= 1'b1;
      end
    end
  end

  always_comb begin
    out_data  = '0;
    out_valid = 1'b0;
    out_last  = 1'b0;
    out_src   = last_src_q;
    a.ready   = 1'b0;
    b.ready   = 1'b0;
    case (state_q)
      pass_a: begin
        out_data  = a.data;
        out_valid = a.valid;
        out_last  = a.last;
        out_src   = 1'b0;
        a.ready   = out_ready;
      end
      pass_b: begin
        out_data  = b.data;
        out_valid = b.valid;
        out_last  = b.last;
        out_src   = 1'b1;
        b.ready   = out_ready;
      end
      default: begin
        out_src = last_src_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/frame_fifo.sv */
`default_nettype none

module frame_fifo import merge_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  frame_stream_if.sink   s,
  frame_stream_if.source m,
  output logic           good,
  output logic           bad,
  output logic           overflow
);

  beat_t mem_data [fifo_depth];
  logic  mem_last [fifo_depth];
  logic  mem_user [fifo_depth];

  // Committed, in-progress and read-visible write pointers
  ptr_t wr_ptr_q;
  ptr_t wr_ptr_d;
  ptr_t wr_ptr_cur_q;
  ptr_t wr_ptr_cur_d;
  ptr_t wr_ptr_vis_q;
  ptr_t rd_ptr_q;

  logic drop_q;
  logic drop_d;
  logic good_d;
  logic bad_d;
  logic overflow_d;
  logic ready_q;
  logic accept;
  logic full_cur;
  logic empty;

  // Registered write port
  logic  wr_en;
  logic  wr_en_q;
  ptr_t  wr_addr_q;
  beat_t wr_data_q;
  logic  wr_last_q;
  logic  wr_user_q;

  // Read pipeline, memory stage then output stage
  logic  rd_en;
  logic  store_out;
  logic  mem_valid_q;
  beat_t mem_data_q;
  logic  mem_last_q;
  logic  mem_user_q;
  logic  out_valid_q;
  beat_t out_data_q;
  logic  out_last_q;
  logic  out_user_q;

  assign s.ready = ready_q;
  assign accept  = s.valid && ready_q;

  // Frame in progress has caught up with the reader
  assign full_cur = (wr_ptr_cur_q[fifo_addr_w] != rd_ptr_q[fifo_addr_w]) &&
                    (wr_ptr_cur_q[fifo_addr_w-1:0] == rd_ptr_q[fifo_addr_w-1:0]);
  assign empty    = (wr_ptr_vis_q == rd_ptr_q);

  always_comb begin
    wr_ptr_d     = wr_ptr_q;
    wr_ptr_cur_d = wr_ptr_cur_q;
    drop_d       = drop_q;
    good_d       = 1'b0;
    bad_d        = 1'b0;
    overflow_d   = 1'b0;
    wr_en        = 1'b0;
    if (accept) begin
      if (full_cur || drop_q) begin
        // Out of space, swallow beats until the end of the frame
        drop_d = 1'b1;
        if (s.last) begin
          wr_ptr_cur_d = wr_ptr_q;
          drop_d       = 1'b0;
          if (s.user) begin
            bad_d = 1'b1;
          end else begin
            overflow_d = 1'b1;
          end
        end
      end else begin
        wr_en        = 1'b1;
        wr_ptr_cur_d = wr_ptr_cur_q + ptr_t'(1);
        if (s.last) begin
          if (s.user) begin
            wr_ptr_cur_d = wr_ptr_q;
            bad_d        = 1'b1;
          end else begin
            wr_ptr_d = wr_ptr_cur_q + ptr_t'(1);
            good_d   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q     <= '0;
      wr_ptr_cur_q <= '0;
      wr_ptr_vis_q <= '0;
      drop_q       <= 1'b0;
      good         <= 1'b0;
      bad          <= 1'b0;
      overflow     <= 1'b0;
      ready_q      <= 1'b0;
      wr_en_q      <= 1'b0;
    end else begin
      wr_ptr_q     <= wr_ptr_d;
      wr_ptr_cur_q <= wr_ptr_cur_d;
      // Reader sees a commit only once its last beat is in memory
      wr_ptr_vis_q <= wr_ptr_q;
      drop_q       <= drop_d;
      good         <= good_d;
      bad          <= bad_d;
      overflow     <= overflow_d;
      ready_q      <= 1'b1;
      wr_en_q      <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr_q <= wr_ptr_cur_q;
    wr_data_q <= s.data;
    wr_last_q <= s.last;
    wr_user_q <= s.user;
    if (wr_en_q) begin
      mem_data[wr_addr_q[fifo_addr_w-1:0]] <= wr_data_q;
      mem_last[wr_addr_q[fifo_addr_w-1:0]] <= wr_last_q;
      mem_user[wr_addr_q[fifo_addr_w-1:0]] <= wr_user_q;
    end
  end

  assign store_out = m.ready || !out_valid_q;
  assign rd_en     = (store_out || !mem_valid_q) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q    <= '0;
      mem_valid_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      if (store_out || !mem_valid_q) begin
        mem_valid_q <= !empty;
      end
      if (store_out) begin
        out_valid_q <= mem_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      mem_data_q <= mem_data[rd_ptr_q[fifo_addr_w-1:0]];
      mem_last_q <= mem_last[rd_ptr_q[fifo_addr_w-1:0]];
      mem_user_q <= mem_user[rd_ptr_q[fifo_addr_w-1:0]];
    end
    if (store_out) begin
      out_data_q <= mem_data_q;
      out_last_q <= mem_last_q;
      out_user_q <= mem_user_q;
    end
  end

  assign m.valid = out_valid_q;
  assign m.data  = out_data_q;
  assign m.last  = out_last_q;
  assign m.user  = out_user_q;

endmodule

`default_nettype wire

/* source/frame_merge_top.sv */
`default_nettype none

module frame_merge_top import merge_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  beat_t a_data,
  input  logic  a_valid,
  output logic  a_ready,
  input  logic  a_last,
  input  logic  a_user,
  input  beat_t b_data,
  input  logic  b_valid,
  output logic  b_ready,
  input  logic  b_last,
  input  logic  b_user,
  output beat_t out_data,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  out_last,
  output port_t out_src,
  output logic  a_good,
  output logic  a_bad,
  output logic  a_overflow,
  output logic  b_good,
  output logic  b_bad,
  output logic  b_overflow
);

  frame_stream_if in_a ();
  frame_stream_if in_b ();
  frame_stream_if fq_a ();
  frame_stream_if fq_b ();

  assign in_a.data  = a_data;
  assign in_a.valid = a_valid;
  assign in_a.last  = a_last;
  assign in_a.user  = a_user;
  assign a_ready    = in_a.ready;

  assign in_b.data  = b_data;
  assign in_b.valid = b_valid;
  assign in_b.last  = b_last;
  assign in_b.user  = b_user;
  assign b_ready    = in_b.ready;

  frame_fifo u_fifo_a (
    .clk      (clk),
    .rst      (rst),
    .s        (in_a.sink),
    .m        (fq_a.source),
    .good     (a_good),
    .bad      (a_bad),
    .overflow (a_overflow)
  );

  frame_fifo u_fifo_b (
    .clk      (clk),
    .rst      (rst),
    .s        (in_b.sink),
    .m        (fq_b.source),
    .good     (b_good),
    .bad      (b_bad),
    .overflow (b_overflow)
  );

  frame_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .a         (fq_a.sink),
    .b         (fq_b.sink),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_src   (out_src)
  );

endmodule

`default_nettype wire

/* source/frame_stream_if.sv */
`default_nettype none

interface frame_stream_if import merge_pkg::*; ();

  beat_t data;
  logic  valid;
  logic  ready;
  logic  last;
  // Bad-frame flag, meaningful on the last beat only
  logic  user;

  modport source (
    output data,
    output valid,
    input  ready,
    output last,
    output user
  );

  modport sink (
    input  data,
    input  valid,
    output ready,
    input  last,
    input  user
  );

endinterface

`default_nettype wire

/* source/merge_pkg.sv */
`default_nettype none

package merge_pkg;

  // Stream and buffer geometry
  localparam int data_w      = 8;
  localparam int fifo_addr_w = 5;
  localparam int fifo_depth  = 32;

  // One byte on the stream
  typedef logic [data_w-1:0] beat_t;

  // FIFO pointer, top bit is the wrap bit
  typedef logic [fifo_addr_w:0] ptr_t;

  // Source tag, 0 is port a and 1 is port b
  typedef logic port_t;

  typedef enum logic [1:0] {
    idle,
    pass_a,
    pass_b
  } arb_state_t;

endpackage

`default_nettype wire
